/* design/sw_pkg.sv */
`default_nettype none

package sw_pkg;

    // alignment scores, wide enough for a 16 x 1023 stripe
    typedef logic signed [13:0] score_t;

    // nucleotide codes as they arrive on the query and reference buses
    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } base_t;

    // number of reference bases in one job
    typedef logic [9:0] ref_len_t;

    // job sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CALC = 2'd1,
        EVAL = 2'd2
    } state_t;

    // stands in for minus infinity, far below any reachable score
    localparam score_t neg_inf = -14'sd4096;

    // affine gap, a gap of length k scores gap_open + (k-1) * gap_extend
    localparam score_t gap_open = -14'sd12;
    localparam score_t gap_extend = -14'sd1;

    // substitution scores
    localparam score_t match_score = 14'sd2;
    localparam score_t mismatch_score = -14'sd3;

endpackage

`default_nettype wire

/* design/sw_pe.sv */
`default_nettype none

module sw_pe (
    input  sw_pkg::base_t  i_query_base,
    input  sw_pkg::base_t  i_ref_base,
    input  sw_pkg::score_t i_diag_score,
    input  sw_pkg::score_t i_top_score,
    input  sw_pkg::score_t i_left_score,
    input  sw_pkg::score_t i_left_ins,
    input  sw_pkg::score_t i_top_del,
    output sw_pkg::score_t o_score,
    output sw_pkg::score_t o_ins,
    output sw_pkg::score_t o_del
);
    import sw_pkg::*;

    score_t ins_open;
    score_t ins_ext;
    score_t del_open;
    score_t del_ext;
    score_t ins_best;
    score_t del_best;
    score_t diag_best;
    score_t gap_best;

    always_comb begin
        // horizontal gap, open from the left cell or extend its gap
        ins_open = i_left_score + gap_open;
        ins_ext = i_left_ins + gap_extend;
        ins_best = (ins_open > ins_ext) ? ins_open : ins_ext;

        // vertical gap, same rule on the cell above
        del_open = i_top_score + gap_open;
        del_ext = i_top_del + gap_extend;
        del_best = (del_open > del_ext) ? del_open : del_ext;

        // substitution from the diagonal
        if (i_query_base == i_ref_base) begin
            diag_best = i_diag_score + match_score;
        end else begin
            diag_best = i_diag_score + mismatch_score;
        end

        gap_best = (ins_best > del_best) ? ins_best : del_best;
    end

    assign o_ins = ins_best;
    assign o_del = del_best;
    assign o_score = (diag_best > gap_best) ? diag_best : gap_best;

endmodule

`default_nettype wire

/* design/pe_array.sv */
`default_nettype none

module pe_array #(
    parameter int N_PE = 16
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_load,
    input  logic [N_PE-1:0] i_enable,
    input  sw_pkg::base_t   i_query_bases [N_PE],
    input  sw_pkg::base_t   i_ref_bases [N_PE],
    input  sw_pkg::score_t  i_diag_score,
    input  sw_pkg::score_t  i_top_score,
    input  sw_pkg::score_t  i_top_del,
    output sw_pkg::score_t  o_cell_scores [N_PE],
    output logic [N_PE-1:0] o_cell_valid
);
    import sw_pkg::*;

    // last cell of each row, seen by the same element as its left neighbour
    score_t score_q [N_PE];
    score_t ins_q [N_PE];
    // deletion score handed to the element below
    score_t del_q [N_PE];

    logic [N_PE-1:0] valid_q;

    for (genvar k = 0; k < N_PE; k++) begin : g_pe
        // left column, a gap of length k+1
        localparam score_t left_init = score_t'(gap_open + gap_extend * k);

        score_t top_score;
        score_t top_del;
        score_t diag_in;
        score_t pe_score;
        score_t pe_ins;
        score_t pe_del;

        if (k == 0) begin : g_first
            // row 0 comes from the controller
            assign top_score = i_top_score;
            assign top_del = i_top_del;
            assign diag_in = i_diag_score;
        end else begin : g_inner
            // corner of the left column one row up
            localparam score_t diag_init = score_t'(gap_open + gap_extend * (k - 1));

            score_t diag_q;

            // previous top score becomes the next diagonal
            always_ff @(posedge i_clk) begin
                if (i_load) begin
                    diag_q <= diag_init;
                end else if (i_enable[k]) begin
                    diag_q <= score_q[k-1];
                end
            end

            assign top_score = score_q[k-1];
            assign top_del = del_q[k-1];
            assign diag_in = diag_q;
        end

        sw_pe i_sw_pe (
            .i_query_base (i_query_bases[k]),
            .i_ref_base   (i_ref_bases[k]),
            .i_diag_score (diag_in),
            .i_top_score  (top_score),
            .i_left_score (score_q[k]),
            .i_left_ins   (ins_q[k]),
            .i_top_del    (top_del),
            .o_score      (pe_score),
            .o_ins        (pe_ins),
            .o_del        (pe_del)
        );

        always_ff @(posedge i_clk) begin
            if (i_load) begin
                score_q[k] <= left_init;
                ins_q[k] <= neg_inf;
                del_q[k] <= neg_inf;
            end else if (i_enable[k]) begin
                score_q[k] <= pe_score;
                ins_q[k] <= pe_ins;
                del_q[k] <= pe_del;
            end
        end
    end

    // scores land one cycle after the enable
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= i_enable;
        end
    end

    assign o_cell_scores = score_q;
    assign o_cell_valid = valid_q;

endmodule

`default_nettype wire

/* design/stripe_ctrl.sv */
`default_nettype none

module stripe_ctrl #(
    parameter int N_PE = 16
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_start,
    input  logic [2*N_PE-1:0]  i_query,
    input  sw_pkg::base_t      i_ref_base,
    output logic               o_load,
    output logic [N_PE-1:0]    o_enable,
    output sw_pkg::base_t      o_query_bases [N_PE],
    output sw_pkg::base_t      o_ref_bases [N_PE],
    output sw_pkg::score_t     o_diag_score,
    output sw_pkg::score_t     o_top_score,
    output sw_pkg::score_t     o_top_del,
    output logic               o_stripe_end,
    output sw_pkg::ref_len_t   o_ref_length
);
    import sw_pkg::*;

    state_t          state_q;
    state_t          state_d;
    logic [N_PE-1:0] enable_q;
    logic            last_en_q;
    logic            feed;
    ref_len_t        length_q;
    base_t           query_q [N_PE];
    base_t           ref_q [N_PE];
    score_t          top_q;
    score_t          diag_q;

    // job starts in the cycle i_start is seen in IDLE
    assign o_load = (state_q == IDLE) && i_start;

    // a reference base enters the array this cycle
    assign feed = o_load || ((state_q == CALC) && i_start);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_start) begin
                    state_d = CALC;
                end
            end
            CALC: begin
                // wavefront has left the last element
                if (last_en_q && !enable_q[N_PE-1]) begin
                    state_d = EVAL;
                end
            end
            EVAL: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= IDLE;
            enable_q <= '0;
            last_en_q <= 1'b0;
            length_q <= '0;
        end else begin
            state_q <= state_d;
            // wavefront moves one element per cycle
            enable_q <= {enable_q[N_PE-2:0], feed};
            last_en_q <= enable_q[N_PE-1];
            if (o_load) begin
                length_q <= ref_len_t'(1);
            end else if ((state_q == CALC) && i_start) begin
                length_q <= length_q + 1'b1;
            end
        end
    end

    // row 0 boundary for element 0, one column per enabled cycle
    always_ff @(posedge i_clk) begin
        if (o_load) begin
            top_q <= gap_open;
            diag_q <= '0;
        end else if (enable_q[0]) begin
            diag_q <= top_q;
            top_q <= top_q + gap_extend;
        end
    end

    // query held for the whole job
    always_ff @(posedge i_clk) begin
        if (o_load) begin
            for (int k = 0; k < N_PE; k++) begin
                query_q[k] <= base_t'(i_query[2*k +: 2]);
            end
        end
    end

    // reference chain follows the enable wavefront
    always_ff @(posedge i_clk) begin
        ref_q[0] <= i_ref_base;
        for (int k = 1; k < N_PE; k++) begin
            ref_q[k] <= ref_q[k-1];
        end
    end

    assign o_enable = enable_q;
    assign o_query_bases = query_q;
    assign o_ref_bases = ref_q;
    assign o_top_score = top_q;
    assign o_diag_score = diag_q;
    // no deletion can come from above row 1
    assign o_top_del = neg_inf;
    assign o_stripe_end = (state_q == EVAL);
    assign o_ref_length = length_q;

endmodule

`default_nettype wire

/* design/stripe_result.sv */
`default_nettype none

module stripe_result #(
    parameter int N_PE = 16
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_load,
    input  sw_pkg::score_t  i_cell_scores [N_PE],
    input  logic [N_PE-1:0] i_cell_valid,
    output sw_pkg::score_t  o_max_score
);
    import sw_pkg::*;

    localparam int LEVELS = $clog2(N_PE);

    // node count at a tree level, odd leftovers pass straight up
    function automatic int level_width(input int lvl);
        return (N_PE + (1 << lvl) - 1) >> lvl;
    endfunction

    wire score_t tree [LEVELS+1][N_PE];

    score_t tree_max;
    score_t max_q;

    // idle elements must not win
    for (genvar n = 0; n < N_PE; n++) begin : g_leaf
        assign tree[0][n] = i_cell_valid[n] ? i_cell_scores[n] : neg_inf;
    end

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        for (genvar n = 0; n < level_width(lvl + 1); n++) begin : g_node
            if (2 * n + 1 < level_width(lvl)) begin : g_pair
                assign tree[lvl+1][n] = (tree[lvl][2*n] > tree[lvl][2*n+1]) ?
                                        tree[lvl][2*n] : tree[lvl][2*n+1];
            end else begin : g_pass
                assign tree[lvl+1][n] = tree[lvl][2*n];
            end
        end
    end

    assign tree_max = tree[LEVELS][0];

    // running maximum over the stripe
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            max_q <= neg_inf;
        end else if (i_load) begin
            max_q <= neg_inf;
        end else if (tree_max > max_q) begin
            max_q <= tree_max;
        end
    end

    assign o_max_score = max_q;

endmodule

`default_nettype wire

/* design/sw_stripe_top.sv */
`default_nettype none

module sw_stripe_top #(
    parameter int N_PE = 16
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  logic [2*N_PE-1:0] i_query,
    input  sw_pkg::base_t     i_ref_base,
    output logic              o_stripe_end,
    output sw_pkg::ref_len_t  o_ref_length,
    output sw_pkg::score_t    o_max_score
);
    import sw_pkg::*;

    logic            load;
    logic [N_PE-1:0] enable;
    base_t           query_bases [N_PE];
    base_t           ref_bases [N_PE];
    score_t          diag_score;
    score_t          top_score;
    score_t          top_del;
    score_t          cell_scores [N_PE];
    logic [N_PE-1:0] cell_valid;

    stripe_ctrl #(
        .N_PE (N_PE)
    ) i_stripe_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_query       (i_query),
        .i_ref_base    (i_ref_base),
        .o_load        (load),
        .o_enable      (enable),
        .o_query_bases (query_bases),
        .o_ref_bases   (ref_bases),
        .o_diag_score  (diag_score),
        .o_top_score   (top_score),
        .o_top_del     (top_del),
        .o_stripe_end  (o_stripe_end),
        .o_ref_length  (o_ref_length)
    );

    pe_array #(
        .N_PE (N_PE)
    ) i_pe_array (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_load        (load),
        .i_enable      (enable),
        .i_query_bases (query_bases),
        .i_ref_bases   (ref_bases),
        .i_diag_score  (diag_score),
        .i_top_score   (top_score),
        .i_top_del     (top_del),
        .o_cell_scores (cell_scores),
        .o_cell_valid  (cell_valid)
    );

    stripe_result #(
        .N_PE (N_PE)
    ) i_stripe_result (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_load        (load),
        .i_cell_scores (cell_scores),
        .i_cell_valid  (cell_valid),
        .o_max_score   (o_max_score)
    );

endmodule

`default_nettype wire

/* dv/sw_ref_model.svh */
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

// software Gotoh recurrence for one stripe
// rows are query bases, columns are reference bases
// expects N_PE, MAX_REF and the sw_pkg names in scope

function automatic int larger(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// substitution score of one query and one reference base
function automatic int pair_score(input base_t q, input base_t r);
    if (q == r) begin
        return match_score;
    end
    return mismatch_score;
endfunction

// highest H over rows 1..N_PE and columns 1..len
function automatic int gotoh_max(
    input logic [2*N_PE-1:0] query,
    input base_t             ref_seq [MAX_REF],
    input int                len
);
    int    h_up [MAX_REF+1];
    int    h_cur [MAX_REF+1];
    int    del_col [MAX_REF+1];
    int    ins;
    int    diag;
    int    best;
    base_t q;

    best = neg_inf;

    // row 0, corner is 0 and a top gap of length j opens then extends
    h_up[0] = 0;
    for (int j = 1; j <= len; j++) begin
        h_up[j] = gap_open + (j - 1) * gap_extend;
        // nothing can be deleted above row 1
        del_col[j] = neg_inf;
    end

    for (int i = 1; i <= N_PE; i++) begin
        q = base_t'(query[2*(i-1) +: 2]);
        // left column, gap of length i
        h_cur[0] = gap_open + (i - 1) * gap_extend;
        ins = neg_inf;
        for (int j = 1; j <= len; j++) begin
            ins = larger(h_cur[j-1] + gap_open, ins + gap_extend);
            del_col[j] = larger(h_up[j] + gap_open, del_col[j] + gap_extend);
            diag = h_up[j-1] + pair_score(q, ref_seq[j-1]);
            h_cur[j] = larger(diag, larger(ins, del_col[j]));
            best = larger(best, h_cur[j]);
        end
        h_up = h_cur;
    end

    return best;
endfunction

`endif

/* dv/sw_stripe_tb.sv */
`default_nettype none

module sw_stripe_tb;
    import sw_pkg::*;

    localparam int N_PE = 16;
    localparam int MAX_REF = 256;
    localparam int N_JOBS = 10;
    localparam int RESET_CYCLES = 16;

    `include "sw_ref_model.svh"

    logic              i_clk;
    logic              i_rst;
    logic              i_start;
    logic [2*N_PE-1:0] i_query;
    base_t             i_ref_base;
    logic              o_stripe_end;
    ref_len_t          o_ref_length;
    score_t            o_max_score;

    // job table
    string             job_name [N_JOBS];
    logic [2*N_PE-1:0] job_query [N_JOBS];
    int                job_len [N_JOBS];
    base_t             job_ref [N_JOBS][MAX_REF];
    ref_len_t          exp_len [N_JOBS];
    score_t            exp_max [N_JOBS];

    int end_count;
    int limit_cycles;
    bit table_ready;

    sw_stripe_top #(
        .N_PE (N_PE)
    ) i_sw_stripe_top (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_query      (i_query),
        .i_ref_base   (i_ref_base),
        .o_stripe_end (o_stripe_end),
        .o_ref_length (o_ref_length),
        .o_max_score  (o_max_score)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // every high cycle of the end strobe
    always @(negedge i_clk) begin
        if (o_stripe_end) begin
            end_count <= end_count + 1;
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_score(input string name, input score_t expected, input score_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_length(input string name, input ref_len_t expected,
                                input ref_len_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // one end strobe cycle per finished job
    task automatic check_pulses(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR %s: expected %0d end strobes, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic build_table();
        int len;
        for (int n = 0; n < N_JOBS; n++) begin
            job_query[n] = $urandom();
            if (n == 0) begin
                job_name[n] = "identity";
                len = N_PE;
            end else if (n >= 5 && n <= 8) begin
                // shorter than the query, boundaries dominate
                job_name[n] = $sformatf("short_%0d", n);
                len = $urandom_range(5, 1);
            end else begin
                job_name[n] = $sformatf("random_%0d", n);
                len = $urandom_range(200, 20);
            end
            job_len[n] = len;
            for (int j = 0; j < MAX_REF; j++) begin
                if (n == 0 && j < N_PE) begin
                    job_ref[n][j] = base_t'(job_query[n][2*j +: 2]);
                end else begin
                    job_ref[n][j] = base_t'($urandom_range(3, 0));
                end
            end
            exp_len[n] = ref_len_t'(len);
            exp_max[n] = score_t'(gotoh_max(job_query[n], job_ref[n], len));
            limit_cycles += len + N_PE + 20;
        end
        // all matches along the diagonal
        check_score("identity_model", score_t'(2 * N_PE), exp_max[0]);
    endtask

    task automatic run_job(input int n);
        @(posedge i_clk);
        check_pulses(job_name[n], n, end_count);
        i_start <= 1'b1;
        i_query <= job_query[n];
        i_ref_base <= job_ref[n][0];
        for (int j = 1; j < job_len[n]; j++) begin
            @(posedge i_clk);
            i_ref_base <= job_ref[n][j];
        end
        @(posedge i_clk);
        i_start <= 1'b0;
        i_ref_base <= BASE_A;
        @(negedge i_clk);
        while (!o_stripe_end) begin
            @(negedge i_clk);
        end
        check_length(job_name[n], exp_len[n], o_ref_length);
        check_score(job_name[n], exp_max[n], o_max_score);
    endtask

    initial begin : watchdog
        wait (table_ready);
        repeat (limit_cycles) @(posedge i_clk);
        $display("timeout waiting for stripe end");
        abort_run();
    end

    initial begin : main
        i_rst = 1'b1;
        i_start = 1'b0;
        i_query = '0;
        i_ref_base = BASE_A;
        end_count = 0;
        limit_cycles = RESET_CYCLES;
        void'($urandom(32'h5955dbce));
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_flag("reset_end", 1'b0, o_stripe_end);
        check_length("reset_length", '0, o_ref_length);
        check_score("reset_max", neg_inf, o_max_score);

        for (int n = 0; n < N_JOBS; n++) begin
            // some jobs follow after idle cycles, the rest back to back
            if (n % 3 == 2) begin
                repeat (4) @(posedge i_clk);
            end
            run_job(n);
        end

        repeat (8) @(negedge i_clk);
        check_pulses("final", N_JOBS, end_count);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+dv
design/sw_pkg.sv
design/sw_pe.sv
design/pe_array.sv
design/stripe_ctrl.sv
design/stripe_result.sv
design/sw_stripe_top.sv
dv/sw_stripe_tb.sv
